/* logic/scan_pkg.sv */
package scan_pkg;

   // Stream id width and the number of saved contexts per engine
   localparam int STREAM_W    = 6;
   localparam int NUM_STREAMS = 64;

   // Engine 0 looks for USER, engine 1 for PASS
   localparam int NUM_ENGINES = 2;

   // One byte of packet payload
   typedef logic [7:0] char_t;

   // Stream tag carried by every packet
   typedef logic [STREAM_W-1:0] stream_t;

   // Stream controls for one cycle, 18 bits in all
   typedef struct packed {
      // Packet start, context is restored on this strobe
      logic    load_state;
      // Forget whatever was saved for this stream
      logic    new_stream;
      stream_t stream;
      // Packet end, context saved and count requested here
      logic    eop;
      logic    char_vld;
      char_t   ch;
   } pkt_ctl_t;

   // Four-character patterns, first character in the top byte
   localparam logic [31:0] PATTERN_USER = "USER";
   localparam logic [31:0] PATTERN_PASS = "PASS";

endpackage

/* logic/stats_pkg.sv */
package stats_pkg;

   // Width of one match counter
   localparam int CNT_W = 16;

   // Requesters are engine 0, engine 1 and the host, in that order
   localparam int NUM_REQ = 3;

   // Operation carried by a request
   typedef enum logic {
      OP_INC  = 1'b0,
      OP_READ = 1'b1
   } stats_op_e;

   // One request to the counter memory, 8 bits
   typedef struct packed {
      stats_op_e         op;
      // Engine index, selects the counter half of a word
      logic              rule;
      scan_pkg::stream_t stream;
   } stats_req_t;

   // Counter memory sequencing
   typedef enum logic [1:0] {
      TBL_IDLE  = 2'd0,
      TBL_READ  = 2'd1,
      TBL_WRITE = 2'd2
   } table_state_e;

endpackage

/* logic/string_dfa.sv */
`timescale 1ns/1ps

module string_dfa #(
   parameter logic [31:0] PATTERN = scan_pkg::PATTERN_USER
) (
   input  logic            clk,
   input  logic            rst_n,
   input  scan_pkg::char_t ch,
   input  logic            char_vld,
   input  logic [2:0]      state_in,
   input  logic            state_in_vld,
   output logic [2:0]      state_out,
   output logic            accept
);

   logic [2:0] state_q;
   logic [2:0] step;
   logic [2:0] fallback;

   // Character idx of the pattern, 0 is the first one
   function automatic scan_pkg::char_t pat_char(input int idx);
      if (idx < 0 || idx > 3)
         return 8'h00;
      return PATTERN[8 * (3 - idx) +: 8];
   endfunction

   // Longest pattern prefix that ends the text "first s pattern chars then c",
   // capped at max_k
   function automatic logic [2:0] fit(input logic [2:0] s, input scan_pkg::char_t c,
                                      input int max_k);
      logic [2:0] best;
      logic       ok;
      best = 3'd0;
      for (int k = 1; k <= 4; k++)
      begin
         ok = (k <= max_k) && (k <= int'(s) + 1) && (pat_char(k - 1) == c);
         // Earlier k-1 characters must line up with the tail of the prefix
         for (int j = 0; j < 3; j++)
         begin
            if ((j < k - 1) && ok && (pat_char(int'(s) - k + 1 + j) != pat_char(j)))
               ok = 1'b0;
         end
         if (ok)
            best = 3'(k);
      end
      return best;
   endfunction

   // Next state for the incoming character, 4 means full match
   assign step = fit(state_q, ch, 4);

   // Where to resume after a full match, a constant of the pattern
   assign fallback = fit(3'd3, pat_char(3), 3);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_q <= 3'd0;
         accept  <= 1'b0;
      end
      else if (state_in_vld)
      begin
         // Restored context wins over any character
         state_q <= state_in;
         accept  <= 1'b0;
      end
      else if (char_vld)
      begin
         accept  <= (step == 3'd4);
         state_q <= (step == 3'd4) ? fallback : step;
      end
      else
         accept <= 1'b0;
   end

   assign state_out = state_q;

endmodule

/* logic/stream_context_matcher.sv */
`timescale 1ns/1ps

module stream_context_matcher #(
   parameter int          ENGINE  = 0,
   parameter logic [31:0] PATTERN = scan_pkg::PATTERN_USER
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  scan_pkg::pkt_ctl_t    ctl,
   input  logic                  enable,
   output logic                  fired,
   output logic                  req,
   output stats_pkg::stats_req_t req_data,
   input  logic                  gnt
);

   // Saved automaton state per stream
   logic [2:0] ctx_mem [scan_pkg::NUM_STREAMS];

   logic [2:0] state_in;
   logic       state_in_vld;
   logic [2:0] state_out;
   logic       accept;
   logic       count_hit;

   // A match on the last character is still in accept during eop
   assign count_hit = ctl.eop & enable & (fired | accept);

   // Load strobe for the automaton, one cycle after packet start
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state_in_vld <= 1'b0;
      else
         state_in_vld <= ctl.load_state;
   end

   // Context restore at packet start and save at an enabled eop
   always_ff @(posedge clk)
   begin
      if (ctl.load_state)
      begin
         // Unknown stream starts from the empty match
         if (ctl.new_stream)
            state_in <= 3'd0;
         else
            state_in <= ctx_mem[ctl.stream];
      end
      // Disabled engine keeps the context from before this packet
      if (ctl.eop && enable)
         ctx_mem[ctl.stream] <= state_out;
   end

   // Per-packet match flag
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         fired <= 1'b0;
      else if (ctl.load_state)
         fired <= 1'b0;
      else if (ctl.eop && !enable)
         fired <= 1'b0;
      else if (accept)
         fired <= 1'b1;
   end

   // Count request, held until the arbiter grants it
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         req <= 1'b0;
      else if (count_hit)
         req <= 1'b1;
      else if (gnt)
         req <= 1'b0;
   end

   // Request contents, fixed from eop until the grant
   always_ff @(posedge clk)
   begin
      if (count_hit)
         req_data <= '{op: stats_pkg::OP_INC, rule: 1'(ENGINE), stream: ctl.stream};
   end

   string_dfa #(
      .PATTERN (PATTERN)
   ) i_string_dfa (
      .clk          (clk),
      .rst_n        (rst_n),
      .ch           (ctl.ch),
      .char_vld     (ctl.char_vld),
      .state_in     (state_in),
      .state_in_vld (state_in_vld),
      .state_out    (state_out),
      .accept       (accept)
   );

endmodule

/* logic/stats_arbiter.sv */
`timescale 1ns/1ps

module stats_arbiter (
   input  logic                                              clk,
   input  logic                                              rst_n,
   input  logic [stats_pkg::NUM_REQ-1:0]                     req,
   input  stats_pkg::stats_req_t [stats_pkg::NUM_REQ-1:0]   req_data,
   input  logic                                              busy,
   output logic [stats_pkg::NUM_REQ-1:0]                     gnt,
   output logic                                              go,
   output stats_pkg::stats_req_t                             go_data
);

   typedef logic [$clog2(stats_pkg::NUM_REQ)-1:0] port_t;

   // Port that won the last grant
   port_t last_q;
   port_t pick;
   logic  pick_vld;
   logic  grant;

   // Walk from farthest to nearest so the nearest requester after last_q wins
   always_comb
   begin
      pick     = last_q;
      pick_vld = 1'b0;
      for (int i = stats_pkg::NUM_REQ; i >= 1; i--)
      begin
         if (req[(int'(last_q) + i) % stats_pkg::NUM_REQ])
         begin
            pick     = port_t'((int'(last_q) + i) % stats_pkg::NUM_REQ);
            pick_vld = 1'b1;
         end
      end
   end

   // Nothing is granted while the table works on an earlier request
   assign grant = pick_vld & ~busy;

   always_comb
   begin
      gnt = '0;
      if (grant)
         gnt[pick] = 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         // Engine 0 goes first after reset
         last_q <= port_t'(stats_pkg::NUM_REQ - 1);
         go     <= 1'b0;
      end
      else
      begin
         go <= grant;
         if (grant)
            last_q <= pick;
      end
   end

   always_ff @(posedge clk)
   begin
      if (grant)
         go_data <= req_data[pick];
   end

endmodule

/* logic/stats_table.sv */
`timescale 1ns/1ps

module stats_table (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           go,
   input  stats_pkg::stats_req_t          go_data,
   output logic                           busy,
   output logic [stats_pkg::CNT_W-1:0]    rd_data,
   output logic                           rd_vld
);

   // One word per stream holds the counters of both engines
   typedef logic [scan_pkg::NUM_ENGINES-1:0][stats_pkg::CNT_W-1:0] word_t;

   word_t                   mem [scan_pkg::NUM_STREAMS];
   word_t                   word_q;
   word_t                   wr_word;
   stats_pkg::stats_req_t   cur_q;
   stats_pkg::table_state_e state_q;
   scan_pkg::stream_t       clr_addr;
   logic                    clearing;

   // Same word back with the selected counter bumped
   always_comb
   begin
      wr_word              = word_q;
      wr_word[cur_q.rule]  = word_q[cur_q.rule] + 1'b1;
   end

   // go counts as busy so the arbiter cannot slip a second grant in
   assign busy = clearing | go | rd_vld | (state_q != stats_pkg::TBL_IDLE);

   assign rd_data = word_q[cur_q.rule];

   // Sequencing and the post-reset clear walk
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_q  <= stats_pkg::TBL_IDLE;
         rd_vld   <= 1'b0;
         clearing <= 1'b1;
         clr_addr <= '0;
      end
      else
      begin
         rd_vld <= 1'b0;
         // One word per cycle, done after NUM_STREAMS cycles
         if (clearing)
         begin
            clr_addr <= clr_addr + 1'b1;
            if (clr_addr == scan_pkg::stream_t'(scan_pkg::NUM_STREAMS - 1))
               clearing <= 1'b0;
         end
         case (state_q)
            stats_pkg::TBL_IDLE:
               if (go)
                  state_q <= stats_pkg::TBL_READ;
            stats_pkg::TBL_READ:
               if (cur_q.op == stats_pkg::OP_INC)
                  state_q <= stats_pkg::TBL_WRITE;
               else
               begin
                  // Host read completes with the word just fetched
                  state_q <= stats_pkg::TBL_IDLE;
                  rd_vld  <= 1'b1;
               end
            default:
               state_q <= stats_pkg::TBL_IDLE;
         endcase
      end
   end

   // Latched request for the operation in flight
   always_ff @(posedge clk)
   begin
      if (go)
         cur_q <= go_data;
   end

   // Memory port, read in TBL_READ and write back in TBL_WRITE
   always_ff @(posedge clk)
   begin
      if (clearing)
         mem[clr_addr] <= '0;
      else if (state_q == stats_pkg::TBL_WRITE)
         mem[cur_q.stream] <= wr_word;
      if (state_q == stats_pkg::TBL_READ)
         word_q <= mem[cur_q.stream];
   end

endmodule

/* logic/packet_scanner_top.sv */
`timescale 1ns/1ps

module packet_scanner_top (
   input  logic                              clk,
   input  logic                              rst_n,
   input  scan_pkg::pkt_ctl_t                ctl,
   input  logic [scan_pkg::NUM_ENGINES-1:0]  enable,
   output logic [scan_pkg::NUM_ENGINES-1:0]  fired,
   input  logic                              host_req,
   input  logic                              host_rule,
   input  scan_pkg::stream_t                 host_stream,
   output logic                              host_gnt,
   output logic [stats_pkg::CNT_W-1:0]       rd_data,
   output logic                              rd_vld
);

   logic                                              req_user;
   logic                                              req_pass;
   stats_pkg::stats_req_t                             data_user;
   stats_pkg::stats_req_t                             data_pass;
   stats_pkg::stats_req_t                             host_data;
   logic [stats_pkg::NUM_REQ-1:0]                     req;
   logic [stats_pkg::NUM_REQ-1:0]                     gnt;
   stats_pkg::stats_req_t [stats_pkg::NUM_REQ-1:0]   req_data;
   logic                                              go;
   stats_pkg::stats_req_t                             go_data;
   logic                                              busy;

   // Host read request
   assign host_data = '{op: stats_pkg::OP_READ, rule: host_rule, stream: host_stream};

   // Port order is engine 0, engine 1, host
   assign req      = {host_req, req_pass, req_user};
   assign req_data = {host_data, data_pass, data_user};
   assign host_gnt = gnt[2];

   stream_context_matcher #(
      .ENGINE  (0),
      .PATTERN (scan_pkg::PATTERN_USER)
   ) i_matcher_user (
      .clk      (clk),
      .rst_n    (rst_n),
      .ctl      (ctl),
      .enable   (enable[0]),
      .fired    (fired[0]),
      .req      (req_user),
      .req_data (data_user),
      .gnt      (gnt[0])
   );

   stream_context_matcher #(
      .ENGINE  (1),
      .PATTERN (scan_pkg::PATTERN_PASS)
   ) i_matcher_pass (
      .clk      (clk),
      .rst_n    (rst_n),
      .ctl      (ctl),
      .enable   (enable[1]),
      .fired    (fired[1]),
      .req      (req_pass),
      .req_data (data_pass),
      .gnt      (gnt[1])
   );

   stats_arbiter i_stats_arbiter (
      .clk      (clk),
      .rst_n    (rst_n),
      .req      (req),
      .req_data (req_data),
      .busy     (busy),
      .gnt      (gnt),
      .go       (go),
      .go_data  (go_data)
   );

   stats_table i_stats_table (
      .clk      (clk),
      .rst_n    (rst_n),
      .go       (go),
      .go_data  (go_data),
      .busy     (busy),
      .rd_data  (rd_data),
      .rd_vld   (rd_vld)
   );

endmodule

/* tb/packet_scanner_tb.sv */
`timescale 1ns/1ps

module packet_scanner_tb;

   localparam int CLK_HALF   = 20;
   localparam int GOLDEN_LEN = 64;
   localparam int RESET_CYC  = 10;
   localparam int SETTLE_CYC = 64;
   localparam int READ_WAIT  = 64;
   // Counts are final this long after eop
   localparam int COUNT_DLY  = 12;

   logic                             clk;
   logic                             rst_n;
   scan_pkg::pkt_ctl_t               ctl;
   logic [scan_pkg::NUM_ENGINES-1:0] enable;
   logic [scan_pkg::NUM_ENGINES-1:0] fired;
   logic                             host_req;
   logic                             host_rule;
   scan_pkg::stream_t                host_stream;
   logic                             host_gnt;
   logic [stats_pkg::CNT_W-1:0]      rd_data;
   logic                             rd_vld;

   // One record per line of the golden file, layout given in the file itself
   logic [127:0] golden [GOLDEN_LEN];
   logic [31:0]  rng_state;
   int           cycle_cnt   = 0;
   int           cycle_limit = 0;
   int           tests_run   = 0;
   int           tests_failed = 0;
   int           errors      = 0;
   int           test_errors = 0;
   int           host_gnt_seen = 0;
   int           host_gnt_mark = 0;

   packet_scanner_top i_packet_scanner_top (
      .clk         (clk),
      .rst_n       (rst_n),
      .ctl         (ctl),
      .enable      (enable),
      .fired       (fired),
      .host_req    (host_req),
      .host_rule   (host_rule),
      .host_stream (host_stream),
      .host_gnt    (host_gnt),
      .rd_data     (rd_data),
      .rd_vld      (rd_vld)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #(CLK_HALF) clk = ~clk;
   end

   // Run limit, set once the golden file is known
   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
      begin
         $display("Run stopped at cycle %0d, the DUT did not finish in time", cycle_cnt);
         $display("Simulation failed");
         $finish;
      end
   end

   // Host grants seen so far, sampled mid-cycle
   always @(negedge clk)
   begin
      if (host_gnt)
         host_gnt_seen <= host_gnt_seen + 1;
   end

   // Gap generator
   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic check_value(input string name, input string what,
                              input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp)
      else
      begin
         $display("[ERROR] %s %s: expected %0h, actual %0h", name, what, exp, act);
         test_errors++;
      end
   endtask

   // One result line per test
   task automatic finish_test(input string name);
      tests_run++;
      if (test_errors == 0)
         $display("%s: ok", name);
      else
      begin
         tests_failed++;
         errors += test_errors;
         $display("%s: failed with %0d errors", name, test_errors);
      end
      test_errors = 0;
   endtask

   // Host request is held until rd_vld, then dropped on the next edge
   task automatic await_read(input string name, input logic [15:0] exp);
      int   waited;
      logic seen;
      waited = 0;
      seen   = 1'b0;
      while (!seen && waited < READ_WAIT)
      begin
         @(negedge clk);
         if (rd_vld)
         begin
            seen = 1'b1;
            check_value(name, "count", 32'(exp), 32'(rd_data));
            // A held request is granted exactly once
            check_value(name, "host grants", 32'd1, 32'(host_gnt_seen - host_gnt_mark));
         end
         waited++;
      end
      @(posedge clk);
      host_req <= 1'b0;
      assert (seen)
      else
      begin
         $display("%s: no read data came back from the counter memory", name);
         test_errors++;
      end
   endtask

   task automatic start_read(input logic [127:0] rec);
      host_gnt_mark = host_gnt_seen;
      host_req    <= 1'b1;
      host_rule   <= rec[24];
      host_stream <= rec[21:16];
   endtask

   task automatic run_packet(input int idx);
      logic [127:0] rec;
      string        name;
      int           nchars;
      int           gap;
      rec    = golden[idx];
      nchars = int'(rec[99:96]);
      name   = $sformatf("pkt%0d_stream%0d", idx, rec[119:112]);
      // Packet start, stream and enable stay put until eop
      @(posedge clk);
      ctl.load_state <= 1'b1;
      ctl.new_stream <= rec[108];
      ctl.stream     <= rec[117:112];
      enable         <= rec[105:104];
      @(posedge clk);
      ctl.load_state <= 1'b0;
      ctl.new_stream <= 1'b0;
      // First character lands after the restored context
      for (int i = 0; i < nchars; i++)
      begin
         @(posedge clk);
         ctl.char_vld <= 1'b1;
         ctl.ch       <= rec[95 - 8 * i -: 8];
      end
      @(posedge clk);
      ctl.char_vld <= 1'b0;
      ctl.eop      <= 1'b1;
      @(posedge clk);
      ctl.eop <= 1'b0;
      // Host read joins the engine requests in the same cycle
      if (rec[28])
         start_read(rec);
      @(negedge clk);
      check_value(name, "fired", 32'(rec[101:100]), 32'(fired));
      if (rec[28])
         await_read(name, rec[15:0]);
      rng_state = xorshift(rng_state);
      gap       = 6 + int'(rng_state[1:0]);
      repeat (gap) @(posedge clk);
      finish_test(name);
   endtask

   task automatic run_count(input int idx);
      logic [127:0] rec;
      string        name;
      rec  = golden[idx];
      name = $sformatf("count_rule%0d_stream%0d", rec[24], rec[23:16]);
      repeat (COUNT_DLY) @(posedge clk);
      @(posedge clk);
      start_read(rec);
      await_read(name, rec[15:0]);
      finish_test(name);
   endtask

   initial
   begin
      int   idx;
      int   budget;
      logic done;
      rst_n       = 1'b0;
      ctl         = '0;
      enable      = '0;
      host_req    = 1'b0;
      host_rule   = 1'b0;
      host_stream = '0;
      rng_state   = 32'h1d3d195e;
      $readmemh("tb/scan_golden.txt", golden);
      // Budget in cycles, record type 00 or unfilled ends the list
      budget = RESET_CYC + SETTLE_CYC;
      done   = 1'b0;
      idx    = 0;
      while (!done && idx < GOLDEN_LEN)
      begin
         if (golden[idx][127:120] === 8'h01)
            budget += 13 + int'(golden[idx][99:96]) + (golden[idx][28] ? READ_WAIT : 0);
         else if (golden[idx][127:120] === 8'h02)
            budget += COUNT_DLY + 2 + READ_WAIT;
         else
            done = 1'b1;
         idx++;
      end
      cycle_limit = 16 * budget;
      repeat (RESET_CYC) @(posedge clk);
      rst_n <= 1'b1;
      // Counter memory clears one word per cycle
      repeat (SETTLE_CYC) @(posedge clk);
      assert (idx > 1)
      else
      begin
         $display("The golden file tb/scan_golden.txt is missing or holds no records");
         errors++;
      end
      done = 1'b0;
      idx  = 0;
      while (!done && idx < GOLDEN_LEN)
      begin
         if (golden[idx][127:120] === 8'h01)
            run_packet(idx);
         else if (golden[idx][127:120] === 8'h02)
            run_count(idx);
         else
            done = 1'b1;
         idx++;
      end
      $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
      if (errors == 0 && tests_run > 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

/* tb/scan_golden.txt */
// type_stream_new/enable_fired/count_chars(first char in top byte)_read(valid rule stream expected)
// type 01 is a packet, 02 a counter readback, 00 ends the list
// USER inside one packet on stream 1
01_01_13_14_5553455200000000_00000000
// USE then R on stream 2, context carries the match
01_02_13_04_5855534500000000_00000000
01_02_03_12_525A000000000000_00000000
// Same split on stream 3 but the second packet starts a new stream
01_03_13_04_4155534500000000_00000000
01_03_13_04_5241424300000000_00000000
// Stream 4, engine 0 disabled in the middle packet
01_04_13_03_5553450000000000_00000000
01_04_02_03_5251510000000000_00000000
01_04_03_11_5200000000000000_00000000
// PASS split over stream 5 with stream 9 in between
01_05_13_03_7850410000000000_00000000
01_09_13_03_5041530000000000_00000000
01_05_03_22_5353000000000000_00000000
01_09_03_02_5151000000000000_00000000
// Both engines fire while the host reads rule 0 stream 1
01_07_13_38_5553455250415353_10010001
// Final counts
02_00_00_00_0000000000000000_10010001
02_00_00_00_0000000000000000_10020001
02_00_00_00_0000000000000000_10030000
02_00_00_00_0000000000000000_10040001
02_00_00_00_0000000000000000_11040000
02_00_00_00_0000000000000000_10050000
02_00_00_00_0000000000000000_11050001
02_00_00_00_0000000000000000_11090000
02_00_00_00_0000000000000000_10070001
02_00_00_00_0000000000000000_11070001
00_00_00_00_0000000000000000_00000000

/* build.f */
logic/scan_pkg.sv
logic/stats_pkg.sv
logic/string_dfa.sv
logic/stream_context_matcher.sv
logic/stats_arbiter.sv
logic/stats_table.sv
logic/packet_scanner_top.sv
tb/packet_scanner_tb.sv

/* Makefile */
VERILATOR = verilator
TOP       = packet_scanner_tb
FILELIST  = build.f
VFLAGS    = --timing --assert --top-module $(TOP) -f $(FILELIST)
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Simulation failed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

sim:
	$(VERILATOR) --binary $(VFLAGS) --Mdir $(OBJ_DIR) -o V$(TOP)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
